//--- stream_cfg_pkg.sv
// stream bridge size definitions
`default_nettype none

package stream_cfg_pkg;

  // width of every block-size field in the bridge
  // the fifo read side and the stream adapter both see this many bits
  localparam int SIZE_WIDTH = 24;

  // number of words held by one closed block
  // a full bank reports DEPTH here and a flushed bank reports fewer
  // a zero never reaches the reader because empty flushes are ignored
  typedef logic [SIZE_WIDTH-1:0] block_size_t;

  // the writer counts with this type too so its close size needs no resizing
  // the adapter compares its sent-word count against a value of this type
  // the largest legal DEPTH is therefore bounded by this width

endpackage : stream_cfg_pkg

// notes for users of this package
//   keep SIZE_WIDTH at 24 so the read interface size stays 24 bits wide
//   DEPTH is a module parameter and lives in the top level
//   DATA_WIDTH is a module parameter and lives in the top level
//   nothing here depends on the clock or reset

`default_nettype wire

//--- fifo_ctrl_pkg.sv
// fifo control state encodings
`default_nettype none

package fifo_ctrl_pkg;

  // which of the two storage banks a write, close or read refers to
  typedef enum logic {
    BANK0 = 1'b0,  // first bank of the ping-pong pair
    BANK1 = 1'b1   // second bank of the ping-pong pair
  } bank_sel_e;

  // writer control state
  typedef enum logic {
    WR_OPEN = 1'b0,  // a bank is open and takes words
    WR_WAIT = 1'b1   // both banks hold closed blocks and the writer stalls
  } wr_state_e;

  // stream adapter state
  typedef enum logic [1:0] {
    RD_IDLE    = 2'd0,  // no block owned and waiting for block_rdy
    RD_SEND    = 2'd1,  // block owned and words go out on the stream
    RD_RELEASE = 2'd2   // act has dropped and the fifo frees the bank
  } rd_state_e;

  // RD_RELEASE keeps the adapter away from block_rdy for one cycle
  // so it never claims the bank that is still being freed

endpackage : fifo_ctrl_pkg

`default_nettype wire

//--- block_writer.sv
// ping-pong block writer
`default_nettype none

module block_writer #(
  parameter int DATA_WIDTH = 32,  // payload width without the user marker
  parameter int DEPTH      = 16   // words per bank
) (
  input  wire                                 i_axi_clk,
  input  wire                                 rst,
  input  wire                                 i_wr_stb,     // one word per pulse
  input  wire  [DATA_WIDTH-1:0]               i_wr_data,
  input  wire                                 i_wr_user,    // travels as the top stored bit
  input  wire                                 i_wr_flush,   // closes a partial block
  input  wire  [1:0]                          i_bank_full,  // one flag per bank from the fifo
  output logic                                o_wr_rdy,
  output logic                                o_wr_en,
  output fifo_ctrl_pkg::bank_sel_e            o_wr_bank,
  output logic [$clog2(DEPTH)-1:0]            o_wr_addr,
  output logic [DATA_WIDTH:0]                 o_wr_word,
  output logic                                o_close,
  output fifo_ctrl_pkg::bank_sel_e            o_close_bank,
  output stream_cfg_pkg::block_size_t         o_close_size
);

  import fifo_ctrl_pkg::*;
  import stream_cfg_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);  // address bits inside one bank

  wr_state_e   state;      // open or stalled on two full banks
  bank_sel_e   open_bank;  // bank that takes the next word
  bank_sel_e   next_bank;  // the other bank of the pair
  block_size_t count;      // words already stored in the open bank
  logic        wr_acc;     // a strobe that is actually taken
  logic        full_hit;   // this word is the DEPTH-th of the bank
  logic        flush_hit;  // flush with at least one word in the bank

  // the writer only takes words while a bank is open
  assign o_wr_rdy  = (state == WR_OPEN);
  assign wr_acc    = i_wr_stb & o_wr_rdy;  // strobes while stalled are dropped
  assign next_bank = (open_bank == BANK0) ? BANK1 : BANK0;

  // the word goes straight into the open bank at the running count
  assign o_wr_en   = wr_acc;
  assign o_wr_bank = open_bank;
  assign o_wr_addr = count[ADDR_W-1:0];   // count stays below DEPTH while open
  assign o_wr_word = {i_wr_user, i_wr_data};  // user marker sits on top

  assign full_hit  = wr_acc & (count == DEPTH - 1);
  // a word arriving with the flush belongs to the block being closed
  assign flush_hit = i_wr_flush & o_wr_rdy & ((count != '0) | wr_acc);

  // close pulse carries the final size including a word taken this cycle
  assign o_close      = full_hit | flush_hit;
  assign o_close_bank = open_bank;
  assign o_close_size = wr_acc ? count + 1'b1 : count;

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state     <= WR_OPEN;  // writer is ready straight out of reset
      open_bank <= BANK0;
      count     <= '0;
    end else begin
      case (state)
        WR_OPEN: begin
          if (o_close) begin
            count     <= '0;  // the next bank starts empty
            open_bank <= next_bank;
            // the other bank may still hold a block the reader has not freed
            state     <= i_bank_full[next_bank] ? WR_WAIT : WR_OPEN;
          end else if (wr_acc) begin
            count <= count + 1'b1;
          end
        end
        WR_WAIT: begin
          if (!i_bank_full[open_bank]) begin
            state <= WR_OPEN;  // reader released the bank we point at
          end
        end
        default: begin
          state <= WR_OPEN;
        end
      endcase
    end
  end

  // a write is only ever issued into a bank the fifo reports free
  a_wr_free_bank : assert property (
    @(posedge i_axi_clk) disable iff (rst)
    o_wr_en |-> (o_wr_rdy && !i_bank_full[o_wr_bank])
  ) else $error("block_writer: write while not ready or into a full bank");

endmodule : block_writer

`default_nettype wire

//--- ping_pong_fifo.sv
// dual bank block fifo
`default_nettype none

module ping_pong_fifo #(
  parameter int DATA_WIDTH = 32,  // payload width without the user marker
  parameter int DEPTH      = 16   // words per bank
) (
  input  wire                                 i_axi_clk,
  input  wire                                 rst,
  // write side from the block writer
  input  wire                                 i_wr_en,
  input  fifo_ctrl_pkg::bank_sel_e            i_wr_bank,
  input  wire  [$clog2(DEPTH)-1:0]            i_wr_addr,
  input  wire  [DATA_WIDTH:0]                 i_wr_word,
  input  wire                                 i_close,       // bank becomes a readable block
  input  fifo_ctrl_pkg::bank_sel_e            i_close_bank,
  input  stream_cfg_pkg::block_size_t         i_close_size,
  output logic [1:0]                          o_bank_full,
  // read side toward the stream adapter
  output logic                                o_block_rdy,
  input  wire                                 i_block_act,   // level held while a block is owned
  output stream_cfg_pkg::block_size_t         o_block_size,
  output logic [DATA_WIDTH:0]                 o_block_data,
  input  wire                                 i_block_stb    // one pulse per word taken
);

  import fifo_ctrl_pkg::*;
  import stream_cfg_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);  // address bits inside one bank

  logic [DATA_WIDTH:0] mem [0:1][0:DEPTH-1];  // both banks side by side
  block_size_t         size_q [0:1];          // size recorded at close time
  logic [1:0]          bank_full;             // set on close and cleared on release
  bank_sel_e           rd_bank;               // bank that is read next
  logic [ADDR_W-1:0]   rd_ptr;                // word offset within the read bank
  logic                act_q;                 // act from the previous cycle
  logic                release_bank;          // act has just dropped

  assign o_bank_full  = bank_full;
  assign release_bank = act_q & ~i_block_act;

  // a block is offered only when the read bank is full and nobody owns it
  // the act_q term keeps the offer down during the release cycle itself
  assign o_block_rdy  = bank_full[rd_bank] & ~i_block_act & ~act_q;

  // the owned block's size and current word are visible while act is high
  assign o_block_size = i_block_act ? size_q[rd_bank] : '0;
  assign o_block_data = i_block_act ? mem[rd_bank][rd_ptr] : '0;

  // storage writes
  always_ff @(posedge i_axi_clk) begin
    if (i_wr_en) begin
      mem[i_wr_bank][i_wr_addr] <= i_wr_word;  // writer guarantees this bank is free
    end
    if (i_close) begin
      size_q[i_close_bank] <= i_close_size;  // latched together with the full flag
    end
  end

  // full flags
  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      bank_full <= 2'b00;  // both banks empty after reset
    end else begin
      if (release_bank) begin
        bank_full[rd_bank] <= 1'b0;  // freed one cycle after act falls
      end
      if (i_close) begin
        bank_full[i_close_bank] <= 1'b1;  // never the bank being released
      end
    end
  end

  // read bank and read pointer
  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      rd_bank <= BANK0;  // the writer also starts on bank 0
      rd_ptr  <= '0;
      act_q   <= 1'b0;
    end else begin
      act_q <= i_block_act;
      if (release_bank) begin
        // banks close in strict alternation so toggling keeps block order
        rd_bank <= (rd_bank == BANK0) ? BANK1 : BANK0;
        rd_ptr  <= '0;  // next block starts at its first word
      end else if (i_block_stb) begin
        rd_ptr <= rd_ptr + 1'b1;  // advances at the end of each strobe cycle
      end
    end
  end

  // the adapter only strobes a block it owns and that is really stored
  a_stb_in_block : assert property (
    @(posedge i_axi_clk) disable iff (rst)
    i_block_stb |-> (i_block_act && bank_full[rd_bank])
  ) else $error("ping_pong_fifo: strobe outside an owned full bank");

endmodule : ping_pong_fifo

`default_nettype wire

//--- block_fifo_to_axis.sv
// block fifo to axi stream adapter
`default_nettype none

module block_fifo_to_axis #(
  parameter int DATA_WIDTH = 32  // stream data width
) (
  input  wire                                 i_axi_clk,
  input  wire                                 rst,
  // block fifo read side
  input  wire                                 i_block_rdy,
  output logic                                o_block_act,   // held while the block is owned
  input  stream_cfg_pkg::block_size_t         i_block_size,
  input  wire  [DATA_WIDTH:0]                 i_block_data,  // user marker on the top bit
  output logic                                o_block_stb,
  // axi stream master
  input  wire                                 i_axi_ready,
  output logic                                o_axi_valid,
  output logic [DATA_WIDTH-1:0]               o_axi_data,
  output logic                                o_axi_user,
  output logic                                o_axi_last
);

  import fifo_ctrl_pkg::*;
  import stream_cfg_pkg::*;

  rd_state_e   state;      // idle, sending or releasing
  block_size_t count;      // words of this block already transferred
  logic        words_left; // at least one word still to go
  logic        final_word; // the word at the head is the last of the block

  assign words_left = (count < i_block_size);
  assign final_word = ((count + 1'b1) >= i_block_size);

  // a word moves on every cycle with valid and ready both high
  assign o_block_stb = i_axi_ready & o_axi_valid;

  // data follows the fifo read pointer with no extra register
  assign o_axi_data = i_block_data[DATA_WIDTH-1:0];
  // user is only meaningful while the block still has words
  assign o_axi_user = words_left ? i_block_data[DATA_WIDTH] : 1'b0;
  // last rides with the final word of the owned block
  assign o_axi_last = final_word & o_block_act & o_axi_valid;

  always_ff @(posedge i_axi_clk) begin
    if (rst) begin
      state       <= RD_IDLE;
      o_block_act <= 1'b0;
      o_axi_valid <= 1'b0;
      count       <= '0;
    end else begin
      o_axi_valid <= 1'b0;  // valid is re-asserted below while words remain
      case (state)
        RD_IDLE: begin
          if (i_block_rdy) begin
            count       <= '0;  // fresh block
            o_block_act <= 1'b1;  // claim it one cycle after rdy is seen
            state       <= RD_SEND;
          end
        end
        RD_SEND: begin
          if (words_left) begin
            o_axi_valid <= 1'b1;  // first valid one cycle after act rises
            if (o_block_stb) begin
              count <= count + 1'b1;
              if (final_word) begin
                o_axi_valid <= 1'b0;  // drops right after the final transfer
              end
            end
          end else begin
            o_block_act <= 1'b0;  // the fifo frees the bank on this fall
            state       <= RD_RELEASE;
          end
        end
        RD_RELEASE: begin
          state <= RD_IDLE;  // one cycle for the fifo to clear the full flag
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // once offered a word stays offered until it is taken
  // valid only ever falls right after the final transfer of the block
  a_valid_holds : assert property (
    @(posedge i_axi_clk) disable iff (rst)
    (o_axi_valid && !o_block_stb) |=> (o_axi_valid && $stable(o_axi_data)
                                       && $stable(o_axi_user) && $stable(o_axi_last))
  ) else $error("block_fifo_to_axis: word changed or withdrawn before transfer");

  // the word that ends the block is always marked with last
  a_fall_after_last : assert property (
    @(posedge i_axi_clk) disable iff (rst)
    $fell(o_axi_valid) |-> $past(o_block_stb && o_axi_last)
  ) else $error("block_fifo_to_axis: valid fell without a final transfer");

endmodule : block_fifo_to_axis

`default_nettype wire

//--- stream_bridge_top.sv
// block streaming bridge top
`default_nettype none

module stream_bridge_top #(
  parameter int DATA_WIDTH = 32,  // word width on both sides
  parameter int DEPTH      = 16   // words per bank and the largest block
) (
  input  wire                       i_axi_clk,
  input  wire                       rst,
  input  wire                       i_wr_stb,
  input  wire  [DATA_WIDTH-1:0]     i_wr_data,
  input  wire                       i_wr_user,
  input  wire                       i_wr_flush,
  output logic                      o_wr_rdy,
  input  wire                       i_axi_ready,
  output logic                      o_axi_valid,
  output logic [DATA_WIDTH-1:0]     o_axi_data,
  output logic                      o_axi_user,
  output logic                      o_axi_last
);

  import fifo_ctrl_pkg::*;
  import stream_cfg_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  // writer to fifo
  logic                wr_en;
  bank_sel_e           wr_bank;
  logic [ADDR_W-1:0]   wr_addr;
  logic [DATA_WIDTH:0] wr_word;     // data plus user marker
  logic                close;
  bank_sel_e           close_bank;
  block_size_t         close_size;
  logic [1:0]          bank_full;   // back to the writer for stalling

  // fifo to adapter
  logic                block_rdy;
  logic                block_act;
  block_size_t         block_size;
  logic [DATA_WIDTH:0] block_data;
  logic                block_stb;

  block_writer #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) block_writer_inst (
    .i_axi_clk(i_axi_clk), .rst(rst),
    .i_wr_stb(i_wr_stb), .i_wr_data(i_wr_data), .i_wr_user(i_wr_user),
    .i_wr_flush(i_wr_flush), .i_bank_full(bank_full), .o_wr_rdy(o_wr_rdy),
    .o_wr_en(wr_en), .o_wr_bank(wr_bank), .o_wr_addr(wr_addr), .o_wr_word(wr_word),
    .o_close(close), .o_close_bank(close_bank), .o_close_size(close_size)
  );

  ping_pong_fifo #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) ping_pong_fifo_inst (
    .i_axi_clk(i_axi_clk), .rst(rst),
    .i_wr_en(wr_en), .i_wr_bank(wr_bank), .i_wr_addr(wr_addr), .i_wr_word(wr_word),
    .i_close(close), .i_close_bank(close_bank), .i_close_size(close_size),
    .o_bank_full(bank_full), .o_block_rdy(block_rdy), .i_block_act(block_act),
    .o_block_size(block_size), .o_block_data(block_data), .i_block_stb(block_stb)
  );

  block_fifo_to_axis #(.DATA_WIDTH(DATA_WIDTH)) block_fifo_to_axis_inst (
    .i_axi_clk(i_axi_clk), .rst(rst),
    .i_block_rdy(block_rdy), .o_block_act(block_act), .i_block_size(block_size),
    .i_block_data(block_data), .o_block_stb(block_stb), .i_axi_ready(i_axi_ready),
    .o_axi_valid(o_axi_valid), .o_axi_data(o_axi_data), .o_axi_user(o_axi_user),
    .o_axi_last(o_axi_last)
  );

endmodule : stream_bridge_top

`default_nettype wire

//--- tb_stream_bridge_top.sv
// stream bridge testbench
`default_nettype none

module tb_stream_bridge_top;

  timeunit 1ns;
  timeprecision 1ps;

  import stream_cfg_pkg::*;

  localparam int DATA_WIDTH   = 32;
  localparam int DEPTH        = 16;
  localparam int READY_HIGH   = 0;     // sink takes every word
  localparam int READY_RANDOM = 1;     // sink takes words on a coin toss
  localparam int READY_LOW    = 2;     // sink stalls completely
  localparam int WAIT_LIMIT   = 2000;  // cycles any single wait may take

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  user;
    logic                  last;
  } beat_t;
  typedef beat_t beat_q_t[$];

  logic                  i_axi_clk;
  logic                  rst;
  logic                  i_wr_stb;
  logic [DATA_WIDTH-1:0] i_wr_data;
  logic                  i_wr_user;
  logic                  i_wr_flush;
  logic                  o_wr_rdy;
  logic                  i_axi_ready;
  logic                  o_axi_valid;
  logic [DATA_WIDTH-1:0] o_axi_data;
  logic                  o_axi_user;
  logic                  o_axi_last;

  beat_t acc_q[$];    // words the writer accepted, in order, last unused
  int    flush_q[$];  // accepted-word count at each flush the writer took
  int    ready_mode;  // how the sink drives ready
  int    rx_idx;      // transfers seen on the stream so far
  int    blk_start;   // stream index of the first word of the current block
  logic  hold_pend;   // a word was offered and not taken at the last sample
  beat_t held;        // that offered word
  int    rnd;

  stream_bridge_top #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) stream_bridge_top_inst (
    .i_axi_clk(i_axi_clk), .rst(rst),
    .i_wr_stb(i_wr_stb), .i_wr_data(i_wr_data), .i_wr_user(i_wr_user),
    .i_wr_flush(i_wr_flush), .o_wr_rdy(o_wr_rdy), .i_axi_ready(i_axi_ready),
    .o_axi_valid(o_axi_valid), .o_axi_data(o_axi_data), .o_axi_user(o_axi_user),
    .o_axi_last(o_axi_last)
  );

  always #4 i_axi_clk = ~i_axi_clk;  // 8 ns period

  // sink side ready pattern, changes only on the rising edge
  always @(posedge i_axi_clk) begin
    case (ready_mode)
      READY_RANDOM: i_axi_ready <= 1'($urandom % 2);
      READY_LOW:    i_axi_ready <= 1'b0;
      default:      i_axi_ready <= 1'b1;
    endcase
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                            input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("error at %0t ns: %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("error at %0t ns: %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_size(input string name, input block_size_t exp, input block_size_t act);
    if (act !== exp) begin
      fail_run($sformatf("error at %0t ns: %s expected %0d got %0d", $time, name, exp, act));
    end
  endtask

  // a block ends after DEPTH words or at a flush that finds words in the open bank
  function automatic beat_q_t build_expected(input beat_t words[$], input int flush_pts[$]);
    beat_q_t out;
    int      fi;
    int      cnt;
    beat_t   b;
    fi  = 0;
    cnt = 0;
    for (int i = 0; i <= words.size(); i++) begin
      while (fi < flush_pts.size() && flush_pts[fi] <= i) begin
        if (cnt > 0) out[out.size()-1].last = 1'b1;  // flush closes a partial block
        cnt = 0;  // a flush on an empty bank changes nothing
        fi++;
      end
      if (i < words.size()) begin
        b      = words[i];
        cnt++;
        b.last = (cnt == DEPTH);  // the DEPTH-th word closes the bank
        if (cnt == DEPTH) cnt = 0;
        out.push_back(b);
      end
    end
    return out;
  endfunction

  // words that belong to closed blocks and must come out
  function automatic int closed_count(input beat_q_t exp);
    int n;
    n = 0;
    for (int i = 0; i < exp.size(); i++) begin
      if (exp[i].last) n = i + 1;
    end
    return n;
  endfunction

  function automatic int ref_block_len(input beat_q_t exp, input int start);
    int i;
    i = start;
    while (i < exp.size() && !exp[i].last) i++;
    return i - start + 1;
  endfunction

  // holds the strobe until the writer is seen ready, retrying dropped strobes
  task automatic write_word(input logic [DATA_WIDTH-1:0] d, input logic u);
    int waited;
    waited = 0;
    @(posedge i_axi_clk);
    i_wr_stb   <= 1'b1;
    i_wr_data  <= d;
    i_wr_user  <= u;
    i_wr_flush <= 1'b0;
    @(negedge i_axi_clk);
    while (!o_wr_rdy) begin
      waited++;
      if (waited > WAIT_LIMIT) fail_run("the writer never became ready to take a word");
      @(negedge i_axi_clk);
    end
    acc_q.push_back({d, u, 1'b0});  // taken at the coming rising edge
  endtask

  task automatic flush_block();
    int waited;
    waited = 0;
    @(posedge i_axi_clk);
    i_wr_stb   <= 1'b0;
    i_wr_flush <= 1'b1;
    @(negedge i_axi_clk);
    while (!o_wr_rdy) begin
      waited++;
      if (waited > WAIT_LIMIT) fail_run("the writer never became ready to take a flush");
      @(negedge i_axi_clk);
    end
    flush_q.push_back(acc_q.size());
    @(posedge i_axi_clk);
    i_wr_flush <= 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge i_axi_clk);
      i_wr_stb   <= 1'b0;
      i_wr_flush <= 1'b0;
    end
  endtask

  // every closed block has fully left the stream
  task automatic wait_drained();
    int      waited;
    beat_q_t exp;
    waited = 0;
    exp    = build_expected(acc_q, flush_q);
    while (rx_idx < closed_count(exp)) begin
      @(posedge i_axi_clk);
      waited++;
      if (waited > WAIT_LIMIT) fail_run("closed blocks did not all leave the stream in time");
    end
  endtask

  task automatic wait_wr_stall();
    int waited;
    waited = 0;
    @(negedge i_axi_clk);
    while (o_wr_rdy) begin
      waited++;
      if (waited > WAIT_LIMIT) fail_run("the writer did not stall with both banks full");
      @(negedge i_axi_clk);
    end
  endtask

  // monitor samples mid-cycle where every output is settled
  always @(negedge i_axi_clk) begin : monitor
    beat_q_t exp;
    if (!rst) begin
      if (hold_pend) begin  // an offered word must sit still until taken
        check_bit("o_axi_valid", 1'b1, o_axi_valid);
        check_data("o_axi_data", held.data, o_axi_data);
        check_bit("o_axi_user", held.user, o_axi_user);
        check_bit("o_axi_last", held.last, o_axi_last);
      end
      if (o_axi_valid && i_axi_ready) begin
        exp = build_expected(acc_q, flush_q);
        if (rx_idx >= exp.size()) begin
          fail_run("the stream carried a word that was never written");
        end else begin
          check_data("o_axi_data", exp[rx_idx].data, o_axi_data);
          check_bit("o_axi_user", exp[rx_idx].user, o_axi_user);
          if (o_axi_last) begin  // the received block ends here
            check_size("block length", block_size_t'(ref_block_len(exp, blk_start)),
                       block_size_t'(rx_idx - blk_start + 1));
            blk_start = rx_idx + 1;
          end
          check_bit("o_axi_last", exp[rx_idx].last, o_axi_last);
          rx_idx++;
        end
      end
      hold_pend = o_axi_valid && !i_axi_ready;
      held      = {o_axi_data, o_axi_user, o_axi_last};
    end
  end

  initial begin : stimulus
    rnd        = $urandom(73);
    i_axi_clk  = 1'b0;
    rst        = 1'b1;
    i_wr_stb   = 1'b0;
    i_wr_data  = '0;
    i_wr_user  = 1'b0;
    i_wr_flush = 1'b0;
    i_axi_ready = 1'b0;
    ready_mode = READY_HIGH;
    rx_idx     = 0;
    blk_start  = 0;
    hold_pend  = 1'b0;
    held       = '0;
    repeat (10) @(posedge i_axi_clk);
    rst <= 1'b0;
    @(negedge i_axi_clk);
    check_bit("o_axi_valid", 1'b0, o_axi_valid);  // quiet stream after reset
    check_bit("o_axi_last", 1'b0, o_axi_last);
    check_bit("o_wr_rdy", 1'b1, o_wr_rdy);
    // three full blocks with a free sink
    for (int i = 0; i < 3 * DEPTH; i++) write_word(DATA_WIDTH'(32'h1000 + i), 1'(i % 2));
    idle_cycles(1);
    wait_drained();
    // partial blocks, and flushes that find an empty bank
    for (int i = 0; i < 5; i++) write_word(DATA_WIDTH'(32'h2000 + i), 1'(i % 3 == 0));
    flush_block();
    flush_block();
    for (int i = 0; i < DEPTH; i++) write_word(DATA_WIDTH'(32'h3000 + i), 1'(i % 2));
    flush_block();
    write_word(DATA_WIDTH'(32'h4000), 1'b1);
    flush_block();
    wait_drained();
    // random words, flushes and gaps under a random sink
    ready_mode <= READY_RANDOM;
    for (int i = 0; i < 5 * DEPTH; i++) begin
      write_word(DATA_WIDTH'($urandom), 1'($urandom % 2));
      if ($urandom % 8 == 0) flush_block();
      else if ($urandom % 4 == 0) idle_cycles(1);
    end
    flush_block();
    wait_drained();
    // stalled sink fills both banks until the writer drops ready
    ready_mode <= READY_LOW;
    for (int i = 0; i < 2 * DEPTH; i++) write_word(DATA_WIDTH'($urandom), 1'($urandom % 2));
    idle_cycles(1);
    wait_wr_stall();
    repeat (20) begin
      @(negedge i_axi_clk);
      check_bit("o_wr_rdy", 1'b0, o_wr_rdy);
    end
    ready_mode <= READY_RANDOM;
    for (int i = 0; i < 2 * DEPTH + 3; i++) write_word(DATA_WIDTH'($urandom), 1'($urandom % 2));
    flush_block();
    wait_drained();
    idle_cycles(20);
    @(negedge i_axi_clk);
    check_bit("o_axi_valid", 1'b0, o_axi_valid);  // nothing left to send
    if (rx_idx == acc_q.size() && rx_idx == closed_count(build_expected(acc_q, flush_q))) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("the number of words received differs from the number written");
    end
  end

endmodule : tb_stream_bridge_top

`default_nettype wire

//--- project.f
stream_cfg_pkg.sv
fifo_ctrl_pkg.sv
block_writer.sv
ping_pong_fifo.sv
block_fifo_to_axis.sv
stream_bridge_top.sv
tb_stream_bridge_top.sv

//--- Bender.yml
package:
  name: stream_bridge

sources:
  # packages come first so every module can import them
  - stream_cfg_pkg.sv
  - fifo_ctrl_pkg.sv
  # design stages and the top level
  - block_writer.sv
  - ping_pong_fifo.sv
  - block_fifo_to_axis.sv
  - stream_bridge_top.sv
  # testbench
  - target: test
    files:
      - tb_stream_bridge_top.sv
